// ==== run_sim.sh ====
#!/bin/sh
# compile and run the scanline planner testbench with Verilator
LOG=sim.log

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_scanline_rw -o sim_scanline
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_scanline > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== scanline_addr_calc.sv ====
// ################################################
// scanline address calculator
// six stage pipeline from window position to bank,
// row, column and length of the next transfer,
// splitting transfers at 128-burst page edges
// ################################################
`timescale 1ns/10ps
`default_nettype none

module scanline_addr_calc
    import scanline_cfg_pkg::*, scanline_xfer_pkg::*;
(
    input  wire                          rst,
    input  wire                          mclk,
    input  frame_cfg_t                   cfg,
    input  recalc_req_t                  recalc,
    input  wire [frame_width_bits-1:0]   curr_x,
    input  wire [frame_height_bits-1:0]  curr_y,
    output xfer_desc_t                   desc,
    output logic                         calc_valid,
    output logic                         last_in_row,
    output logic                         last_row
);

    localparam logic [xfer_bits:0] xfer_max  = 1 << xfer_bits;  // 64 bursts
    localparam logic [col8_bits:0] page_size = 1 << col8_bits;  // 128 bursts

    logic [4:0]                   step;         // one-hot stage enables 2..6
    logic                         continued;    // next transfer finishes a split chunk
    logic [xfer_bits-1:0]         leftover;     // bursts left for the continuation

    logic [frame_width_bits-1:0]  frame_x;
    logic [frame_height_bits-1:0] frame_y;
    logic [frame_height_bits:0]   next_y;
    logic [frame_width_bits:0]    row_left;     // bursts left in the window row
    logic [2:0]                   bank;
    logic [26:0]                  prod_w;
    logic [burst_addr_bits-1:0]   line_offs;    // line group times full width
    logic [burst_addr_bits-1:0]   line_start;
    logic [burst_addr_bits-1:0]   row_col;
    logic [xfer_bits:0]           lim_by_xfer;  // min(row_left, 64)
    logic [col8_bits:0]           page_left_w;  // 1..128
    logic                         limited_w;
    logic [xfer_bits:0]           remainder_w;
    logic [xfer_bits:0]           page_len;
    logic                         page_lim;
    logic [xfer_bits:0]           remainder;
    logic [xfer_bits:0]           len_w;

    assign prod_w      = frame_y[frame_height_bits-1:3] * cfg.full_width;
    assign page_left_w = page_size - {1'b0, row_col[col8_bits-1:0]};
    assign limited_w   = page_left_w < {1'b0, lim_by_xfer};
    assign remainder_w = lim_by_xfer - page_left_w[xfer_bits:0];
    assign len_w       = continued ? {1'b0, leftover} : page_len;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            step       <= '0;
            calc_valid <= 1'b0;
            continued  <= 1'b0;
        end else begin
            step <= {step[3:0] & {4{~recalc.stb}}, recalc.stb}; // new strobe flushes
            if (recalc.stb)   calc_valid <= 1'b0;
            else if (step[4]) calc_valid <= 1'b1;               // 6 cycles after strobe
            if (recalc.stb) begin
                if (recalc.restart)      continued <= 1'b0;
                else if (recalc.advance) continued <= desc.partial; // issued half of a split
            end
        end
    end

    always_ff @(posedge rst) begin
        if (recalc.stb) begin // stage 1, frame position
            frame_x  <= curr_x + cfg.window_x0;
            frame_y  <= curr_y + cfg.window_y0;
            next_y   <= curr_y + 1'b1;
            row_left <= cfg.window_width - curr_x;
        end
        if (step[0]) begin // stage 2, line group times padded width
            line_offs <= prod_w[burst_addr_bits-1:0];
            bank      <= frame_y[2:0];
        end
        if (step[1]) line_start <= cfg.start_addr + line_offs; // stage 3
        if (step[2]) begin // stage 4
            row_col     <= line_start + {{(burst_addr_bits-frame_width_bits){1'b0}}, frame_x};
            lim_by_xfer <= (|row_left[frame_width_bits:xfer_bits]) ?
                           xfer_max : row_left[xfer_bits:0];
        end
        if (step[3]) begin // stage 5, page limit
            page_len  <= limited_w ? page_left_w[xfer_bits:0] : lim_by_xfer;
            page_lim  <= limited_w;
            remainder <= remainder_w;
        end
        if (step[4]) begin // stage 6, continuation or fresh chunk
            desc.bank    <= bank;
            desc.row     <= row_col[burst_addr_bits-1:col8_bits];
            desc.col     <= row_col[col8_bits-1:0];
            desc.num128  <= len_w[xfer_bits-1:0]; // 64 wraps to 0
            desc.partial <= page_lim && !continued;
            if (!continued) leftover <= remainder[xfer_bits-1:0];
            last_in_row  <= row_left == {{(frame_width_bits-xfer_bits){1'b0}}, len_w};
            last_row     <= next_y == cfg.window_height;
        end
    end

endmodule

`default_nettype wire

// ==== scanline_cfg_pkg.sv ====
// ################################################
// scanline configuration package
// register map, field widths and the frame layout
// programmed by firmware
// ################################################
`default_nettype none

package scanline_cfg_pkg;

    localparam int row_bits          = 15; // memory row address
    localparam int col8_bits         = 7;  // column in 8-bursts, one page is 128 bursts
    localparam int burst_addr_bits   = 22; // {row, col8}
    localparam int frame_width_bits  = 13; // frame or window x in bursts
    localparam int frame_height_bits = 16; // line number
    localparam int xfer_bits         = 6;  // transfer length, 0 means 64

    typedef enum logic [2:0] {
        op_mode         = 3'd0, // {write, enable, run}
        op_start_addr   = 3'd2, // frame start in {row, col8}, bank 0
        op_full_width   = 3'd3, // padded line width, 0 means 8192
        op_window_wh    = 3'd4, // low half width, high half height
        op_window_x0y0  = 3'd5, // window origin in the frame
        op_window_start = 3'd6  // start point inside the window
    } cmd_op_t;

    typedef struct packed {
        logic        stb;  // one cycle write strobe
        cmd_op_t     op;
        logic [31:0] data;
    } cmd_t;

    typedef struct packed {
        logic write;  // 1 writes to memory, 0 reads
        logic enable; // allow new requests
        logic run;    // low holds the channel in reset
    } mode_t;

    typedef struct packed {
        logic [burst_addr_bits-1:0]   start_addr;
        logic [frame_width_bits:0]    full_width;    // msb is the carry for a zero write
        logic [frame_width_bits:0]    window_width;
        logic [frame_height_bits:0]   window_height;
        logic [frame_width_bits-1:0]  window_x0;
        logic [frame_height_bits-1:0] window_y0;
        logic [frame_width_bits-1:0]  start_x;       // relative to the window
        logic [frame_height_bits-1:0] start_y;
        mode_t                        mode;
    } frame_cfg_t;

endpackage

`default_nettype wire

// ==== scanline_regs.sv ====
// ################################################
// scanline register file
// decodes parallel command writes into the frame
// configuration and flags each accepted write
// ################################################
`timescale 1ns/10ps
`default_nettype none

module scanline_regs
    import scanline_cfg_pkg::*;
(
    input  wire        rst,
    input  wire        mclk,
    input  cmd_t       cmd,
    output frame_cfg_t cfg,
    output logic       cfg_wr
);

    logic lo_zero; // low field all zero, sets the carry bit
    logic hi_zero;

    assign lo_zero = ~|cmd.data[frame_width_bits-1:0];
    assign hi_zero = ~|cmd.data[31:16];

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            cfg    <= '0; // mode 0 keeps the channel in reset
            cfg_wr <= 1'b0;
        end else begin
            cfg_wr <= 1'b0;
            if (cmd.stb) begin
                cfg_wr <= 1'b1;
                case (cmd.op)
                    op_mode:       cfg.mode <= mode_t'(cmd.data[2:0]);
                    op_start_addr: cfg.start_addr <= cmd.data[burst_addr_bits-1:0];
                    op_full_width: begin
                        cfg.full_width <= {lo_zero, cmd.data[frame_width_bits-1:0]};
                    end
                    op_window_wh: begin
                        cfg.window_width  <= {lo_zero, cmd.data[frame_width_bits-1:0]};
                        cfg.window_height <= {hi_zero, cmd.data[31:16]}; // 0 -> 65536
                    end
                    op_window_x0y0: begin
                        cfg.window_x0 <= cmd.data[frame_width_bits-1:0];
                        cfg.window_y0 <= cmd.data[31:16];
                    end
                    op_window_start: begin
                        cfg.start_x <= cmd.data[frame_width_bits-1:0];
                        cfg.start_y <= cmd.data[31:16];
                    end
                    default: cfg_wr <= 1'b0; // unmapped address, ignored
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== scanline_rw.sv ====
// ################################################
// scanline read/write planner top level
// register file, address pipeline and transfer
// sequencer of one memory channel
// ################################################
`timescale 1ns/10ps
`default_nettype none

module scanline_rw
    import scanline_cfg_pkg::*, scanline_xfer_pkg::*;
(
    input  wire        rst,
    input  wire        mclk,
    input  cmd_t       cmd,
    input  wire        frame_start,
    input  wire        xfer_grant,
    input  wire        xfer_done,
    output logic       xfer_want,
    output logic       xfer_start_rd,
    output logic       xfer_start_wr,
    output xfer_desc_t xfer,
    output logic       frame_done,
    output logic       frame_finished
);

    frame_cfg_t                   cfg;
    logic                         cfg_wr;      // one cycle, cfg already updated
    recalc_req_t                  recalc;
    logic [frame_width_bits-1:0]  curr_x;      // transfer start in the window
    logic [frame_height_bits-1:0] curr_y;
    logic                         calc_valid;
    logic                         last_in_row;
    logic                         last_row;

    scanline_regs scanline_regs_inst (
        .rst    (rst),
        .mclk   (mclk),
        .cmd    (cmd),
        .cfg    (cfg),
        .cfg_wr (cfg_wr)
    );

    scanline_addr_calc scanline_addr_calc_inst (
        .rst         (rst),
        .mclk        (mclk),
        .cfg         (cfg),
        .recalc      (recalc),
        .curr_x      (curr_x),
        .curr_y      (curr_y),
        .desc        (xfer),       // held stable from want until start
        .calc_valid  (calc_valid),
        .last_in_row (last_in_row),
        .last_row    (last_row)
    );

    scanline_sequencer scanline_sequencer_inst (
        .rst            (rst),
        .mclk           (mclk),
        .cfg            (cfg),
        .cfg_wr         (cfg_wr),
        .frame_start    (frame_start),
        .xfer_grant     (xfer_grant),
        .xfer_done      (xfer_done),
        .desc_num128    (xfer.num128),
        .calc_valid     (calc_valid),
        .last_in_row    (last_in_row),
        .last_row       (last_row),
        .recalc         (recalc),
        .curr_x         (curr_x),
        .curr_y         (curr_y),
        .xfer_want      (xfer_want),
        .xfer_start_rd  (xfer_start_rd),
        .xfer_start_wr  (xfer_start_wr),
        .frame_done     (frame_done),
        .frame_finished (frame_finished)
    );

endmodule

`default_nettype wire

// ==== scanline_sequencer.sv ====
// ################################################
// scanline transfer sequencer
// walks the window, runs the want/grant/start
// exchange, counts transfers in flight and marks
// the end of the frame
// ################################################
`timescale 1ns/10ps
`default_nettype none

module scanline_sequencer
    import scanline_cfg_pkg::*, scanline_xfer_pkg::*;
(
    input  wire                          rst,
    input  wire                          mclk,
    input  frame_cfg_t                   cfg,
    input  wire                          cfg_wr,
    input  wire                          frame_start,
    input  wire                          xfer_grant,
    input  wire                          xfer_done,
    input  wire [xfer_bits-1:0]          desc_num128,
    input  wire                          calc_valid,
    input  wire                          last_in_row,
    input  wire                          last_row,
    output recalc_req_t                  recalc,
    output logic [frame_width_bits-1:0]  curr_x,
    output logic [frame_height_bits-1:0] curr_y,
    output logic                         xfer_want,
    output logic                         xfer_start_rd,
    output logic                         xfer_start_wr,
    output logic                         frame_done,
    output logic                         frame_finished
);

    seq_state_t         state;
    logic [1:0]         pending;     // started but not yet done
    logic               xfer_done_d;
    logic               chn_rst;
    logic               chn_en;
    logic               reenable;    // leaving channel reset
    logic               started;
    logic               busy;
    logic               pre_want;
    logic               done_cond;
    logic [xfer_bits:0] xfer_len;

    assign chn_rst   = ~cfg.mode.run;
    assign chn_en    = cfg.mode.run & cfg.mode.enable;
    assign reenable  = (state == st_off) && cfg.mode.run;
    assign started   = xfer_start_rd | xfer_start_wr;
    assign busy      = (state == st_busy) || (state == st_drain);
    assign xfer_len  = {desc_num128 == '0, desc_num128}; // 0 means 64
    assign done_cond = (state == st_drain) && xfer_done_d && (pending == 2'd0);
    // no want while a recalculation is about to start or just started
    assign pre_want  = chn_en && (state == st_busy) && !xfer_want && calc_valid &&
                       (pending != 2'd3) && !started && !frame_start && !cfg_wr &&
                       !recalc.stb;

    always_ff @(posedge rst or posedge mclk) begin
        if (mclk) begin
            state          <= st_off;
            pending        <= '0;
            xfer_done_d    <= 1'b0;
            recalc         <= '0;
            curr_x         <= '0;
            curr_y         <= '0;
            xfer_want      <= 1'b0;
            xfer_start_rd  <= 1'b0;
            xfer_start_wr  <= 1'b0;
            frame_done     <= 1'b0;
            frame_finished <= 1'b0;
        end else begin
            if (chn_rst) state <= st_off;
            else begin
                case (state)
                    st_off:   state <= st_idle;
                    st_idle:  if (frame_start) state <= st_busy;
                    st_busy: begin
                        if (!frame_start && started && last_in_row && last_row)
                            state <= st_drain; // last block of the window issued
                    end
                    st_drain: begin
                        if (frame_start)    state <= st_busy;
                        else if (done_cond) state <= st_idle;
                    end
                    default:  state <= st_off;
                endcase
            end

            recalc.stb     <= ((started | frame_start) & ~chn_rst) | cfg_wr | reenable;
            recalc.advance <= started;
            recalc.restart <= frame_start | reenable;

            if (chn_rst || frame_start) begin
                curr_x <= cfg.start_x;
                curr_y <= cfg.start_y;
            end else if (started) begin
                curr_x <= last_in_row ? '0 : curr_x + xfer_len;
                if (last_in_row) curr_y <= curr_y + 1'b1;
            end

            if (chn_rst || xfer_grant) xfer_want <= 1'b0;
            else if (pre_want)         xfer_want <= 1'b1;
            xfer_start_rd <= xfer_grant && !chn_rst && !cfg.mode.write;
            xfer_start_wr <= xfer_grant && !chn_rst && cfg.mode.write;

            xfer_done_d <= xfer_done;
            if (chn_rst || !busy)         pending <= '0;
            else if (started && !xfer_done) pending <= pending + 1'b1;
            else if (!started && xfer_done) pending <= pending - 1'b1;

            frame_done <= done_cond;
            if (chn_rst || frame_start) frame_finished <= 1'b0;
            else if (done_cond)         frame_finished <= 1'b1; // rises with frame_done
        end
    end

endmodule

`default_nettype wire

// ==== scanline_xfer_pkg.sv ====
// ################################################
// scanline transfer package
// transfer descriptor, recalculation request and
// sequencer state encoding
// ################################################
`default_nettype none

package scanline_xfer_pkg;

    import scanline_cfg_pkg::*;

    typedef struct packed {
        logic [2:0]           bank;    // frame line mod 8
        logic [row_bits-1:0]  row;
        logic [col8_bits-1:0] col;     // start column in 8-bursts
        logic [xfer_bits-1:0] num128;  // bursts to move, 0 means 64
        logic                 partial; // first half of a page split
    } xfer_desc_t;

    typedef struct packed {
        logic stb;     // start a recalculation
        logic advance; // follows an issued transfer
        logic restart; // frame start or channel re-enable
    } recalc_req_t;

    typedef enum logic [1:0] {
        st_off,   // channel held in reset
        st_idle,  // waiting for a frame start
        st_busy,  // walking the window
        st_drain  // last block issued, waiting for completions
    } seq_state_t;

endpackage

`default_nettype wire

// ==== tb_scanline_rw.sv ====
// ################################################
// testbench for the scanline read/write planner
// directed frames checked against a model of the
// window walk, random grant and done responder
// ################################################
`timescale 1ns/10ps
`default_nettype none

module tb_scanline_rw
    import scanline_cfg_pkg::*, scanline_xfer_pkg::*;
();

    localparam int max_cycles = 20000; // six frames of at most ~1500 cycles, wide margin

    typedef struct packed {
        logic       wr;   // started on xfer_start_wr
        xfer_desc_t desc;
    } seen_t;

    logic       rst = 1'b0;        // clock
    logic       mclk;              // reset, active high
    cmd_t       cmd;
    logic       frame_start;
    logic       xfer_grant = 1'b0;
    logic       xfer_done = 1'b0;
    logic       xfer_want;
    logic       xfer_start_rd;
    logic       xfer_start_wr;
    xfer_desc_t xfer;
    logic       frame_done;
    logic       frame_finished;

    integer     seed = 32'h5043d697;
    int         cycles = 0;
    int         error_cnt = 0;
    int         wait_cnt = -1;     // grant delay, -1 when idle
    int         late_extra = 0;    // added done latency
    int         outstanding = 0;   // started, done not yet driven
    int         peak = 0;
    int         due_q[$];          // cycle of each pending done
    seen_t      seen_q[$];
    xfer_desc_t exp_q[$];

    int         start_addr;        // layout of the current frame
    int         full_w;
    int         win_w;
    int         win_h;
    int         win_x0;
    int         win_y0;
    int         st_x;
    int         st_y;
    logic       wr_mode;

    scanline_rw scanline_rw_inst (.*);

    always #2 rst = ~rst;

    task automatic abort_run(input string msg);
        error_cnt++;
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_eq(input string test, input string what,
                             input longint exp, input longint act);
        assert (exp == act) else
            abort_run($sformatf("Fail %s %s: expected %0h actual %0h", test, what, exp, act));
    endtask

    always @(posedge rst) begin
        cycles++;
        if (cycles >= max_cycles) abort_run("timeout, the DUT stopped finishing frames");
    end

    // start monitor, done scheduler and grant responder
    always @(negedge rst) begin
        assert (!(xfer_start_rd && xfer_start_wr)) else
            abort_run("both start outputs pulsed in the same cycle");
        if (xfer_start_rd || xfer_start_wr) begin
            seen_q.push_back(seen_t'({xfer_start_wr, xfer}));
            outstanding++;
            due_q.push_back(cycles + 1 + {$random(seed)} % 5 + late_extra); // 1..5 cycles
        end
        peak = (outstanding > peak) ? outstanding : peak;
        assert (outstanding <= 3) else abort_run("more than 3 transfers were pending");
        if (frame_done) begin
            assert (outstanding == 0) else abort_run("frame_done came before the last done");
            expect_eq("frame_done", "frame_finished", 1, frame_finished);
        end
        xfer_done = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycles) begin
            xfer_done = 1'b1;
            void'(due_q.pop_front());
            outstanding--;
        end
        xfer_grant = 1'b0;
        if (!xfer_want) begin
            wait_cnt = -1;
        end else begin
            if (wait_cnt < 0) wait_cnt = {$random(seed)} % 4; // answer after 0..3 cycles
            if (wait_cnt == 0) xfer_grant = 1'b1;
            wait_cnt--;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge rst);
    endtask

    task automatic write_reg(input cmd_op_t op, input logic [31:0] data);
        @(negedge rst);
        cmd = cmd_t'({1'b1, op, data});
        @(negedge rst);
        cmd = '0;
    endtask

    task automatic setup_frame(input int addr, input int fw, input int w, input int h,
                               input int x0, input int y0, input int sx, input int sy,
                               input logic wr);
        start_addr = addr;
        full_w     = fw;
        win_w      = w;
        win_h      = h;
        win_x0     = x0;
        win_y0     = y0;
        st_x       = sx;
        st_y       = sy;
        wr_mode    = wr;
        write_reg(op_start_addr, addr);
        write_reg(op_full_width, fw);
        write_reg(op_window_wh, {h[15:0], w[15:0]});
        write_reg(op_window_x0y0, {y0[15:0], x0[15:0]});
        write_reg(op_window_start, {sy[15:0], sx[15:0]});
        write_reg(op_mode, {29'd0, wr, 2'b11}); // enable and run
    endtask

    // expected descriptors of a whole frame walk
    task automatic plan_frame();
        int          x;
        int          y;
        int          line;
        int          lim;
        int          page_left;
        int          len;
        int          carry;
        logic [21:0] addr;
        xfer_desc_t  d;
        exp_q.delete();
        x     = st_x;
        y     = st_y;
        carry = 0;
        while (y < win_h) begin
            line      = win_y0 + y;
            addr      = start_addr + (line / 8) * full_w + win_x0 + x;
            lim       = (win_w - x < 64) ? win_w - x : 64;
            page_left = 128 - addr[6:0];
            d.partial = 1'b0;
            if (carry != 0) begin
                len   = carry; // rest of a split chunk
                carry = 0;
            end else if (page_left < lim) begin
                len       = page_left;
                carry     = lim - page_left;
                d.partial = 1'b1;
            end else begin
                len = lim;
            end
            d.bank   = line % 8;
            d.row    = addr[21:7];
            d.col    = addr[6:0];
            d.num128 = len[5:0];   // 64 wraps to 0
            exp_q.push_back(d);
            x = x + len;
            if (x >= win_w) begin
                x = 0;
                y++;
            end
        end
    endtask

    task automatic run_frame(input string test);
        int lag;
        lag = 0;
        plan_frame();
        seen_q.delete();
        @(negedge rst);
        frame_start = 1'b1;
        @(negedge rst);
        frame_start = 1'b0;
        while (!xfer_want) begin
            lag++;
            @(negedge rst);
        end
        assert (lag >= 7) else abort_run($sformatf("%s: xfer_want rose too early", test));
        do @(negedge rst); while (!frame_done);
        idle(4);
        expect_eq(test, "frame_finished held", 1, frame_finished);
        expect_eq(test, "transfer count", exp_q.size(), seen_q.size());
        foreach (exp_q[i]) begin
            expect_eq(test, $sformatf("descriptor %0d", i), exp_q[i], seen_q[i].desc);
            expect_eq(test, "start output", wr_mode, seen_q[i].wr);
        end
    endtask

    task automatic test_reset_values();
        expect_eq("reset", "xfer_want", 0, xfer_want);
        expect_eq("reset", "xfer_start_rd", 0, xfer_start_rd);
        expect_eq("reset", "xfer_start_wr", 0, xfer_start_wr);
        expect_eq("reset", "frame_done", 0, frame_done);
        expect_eq("reset", "frame_finished", 0, frame_finished);
    endtask

    task automatic test_single_line();
        setup_frame('h100, 200, 40, 1, 8, 3, 0, 0, 1'b0);
        run_frame("single_line");
        expect_eq("single_line", "partial", 0, seen_q[0].desc.partial);
    endtask

    task automatic test_multi_line();
        setup_frame('h2000, 300, 20, 4, 30, 5, 0, 0, 1'b0); // lines 5..8 span two groups
        run_frame("multi_line");
    endtask

    task automatic test_page_split();
        setup_frame(0, 256, 50, 1, 100, 0, 0, 0, 1'b0); // 28 up to the page edge, 22 after
        run_frame("page_split");
        expect_eq("page_split", "first partial", 1, seen_q[0].desc.partial);
        expect_eq("page_split", "split sum", 50,
                  seen_q[0].desc.num128 + seen_q[1].desc.num128);
    endtask

    task automatic test_wide_rows();
        setup_frame(0, 256, 150, 2, 0, 0, 0, 0, 1'b1);
        run_frame("wide_rows");
        expect_eq("wide_rows", "first length", 0, seen_q[0].desc.num128);
    endtask

    task automatic test_late_done();
        late_extra = 40;
        peak       = 0;
        setup_frame(0, 256, 200, 1, 0, 0, 0, 0, 1'b0);
        run_frame("late_done");
        expect_eq("late_done", "peak pending", 3, peak);
        late_extra = 0;
    endtask

    task automatic test_channel_reset();
        int n_seen;
        write_reg(op_mode, 0);
        idle(2);
        expect_eq("channel_reset", "frame_finished", 0, frame_finished);
        setup_frame('h400, 256, 64, 40, 0, 0, 0, 0, 1'b0);
        seen_q.delete();
        @(negedge rst);
        frame_start = 1'b1;
        @(negedge rst);
        frame_start = 1'b0;
        while (seen_q.size() < 3) @(posedge rst);
        write_reg(op_mode, 0); // drop run mid-frame
        idle(2);
        n_seen = seen_q.size();
        repeat (20) begin // a running channel would request again within 8 cycles
            @(negedge rst);
            expect_eq("channel_reset", "xfer_want", 0, xfer_want);
        end
        expect_eq("channel_reset", "starts in reset", n_seen, seen_q.size());
        expect_eq("channel_reset", "frame_finished", 0, frame_finished);
        while (outstanding != 0) @(posedge rst);
        setup_frame('h400, 256, 30, 4, 0, 0, 10, 2, 1'b0);
        run_frame("restart");
    endtask

    initial begin
        mclk        = 1'b1;
        cmd         = '0;
        frame_start = 1'b0;
        repeat (3) @(negedge rst);
        mclk = 1'b0;
        test_reset_values();
        test_single_line();
        test_multi_line();
        test_page_split();
        test_wide_rows();
        test_late_done();
        test_channel_reset();
        if (error_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
scanline_cfg_pkg.sv
scanline_xfer_pkg.sv
scanline_regs.sv
scanline_addr_calc.sv
scanline_sequencer.sv
scanline_rw.sv
tb_scanline_rw.sv
